// ==== include/vex_params.svh ====
`ifndef VEX_PARAMS_SVH
`define VEX_PARAMS_SVH

// lanes, also elements per micro-op
`define VEX_LANES 4

// element slot width
`define VEX_ELEM_W 32

// full v0 mask register
`define VEX_V0_W 128

// vector length, up to 16 elements
`define VEX_VL_W 5

`endif

// ==== design/vex_pkg.sv ====
`default_nettype none

package vex_pkg;

    typedef enum logic [3:0] {
        VALU_ADD,
        VALU_SUB,
        VALU_AND,
        VALU_OR,
        VALU_XOR,
        VALU_MIN,
        VALU_MAX,
        VALU_MINU,
        VALU_MAXU,
        VALU_SEQ,
        VALU_SNE,
        VALU_SLT,
        VALU_SLTU,
        VALU_SLE,
        VALU_SGT
    } valuop_t;

    // scalar operand truncation width
    typedef enum logic [1:0] {
        SEW8,
        SEW16,
        SEW32
    } sew_t;

    typedef enum logic [1:0] {
        OPB_VEC,
        OPB_SCALAR,
        OPB_IMM
    } opb_sel_t;

    // compares produce mask bits, not element results
    function automatic logic is_cmp(valuop_t op);
        return op inside {VALU_SEQ, VALU_SNE, VALU_SLT, VALU_SLTU, VALU_SLE, VALU_SGT};
    endfunction

endpackage

`default_nettype wire

// ==== design/vex_lane_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vex_params.svh"

module vex_lane_alu (
    input  logic                   CLK,
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  vex_pkg::valuop_t       valuop,
    input  vex_pkg::sew_t          vsew,
    input  logic                   vsignext,
    input  vex_pkg::opb_sel_t      opb_sel,
    input  logic [`VEX_ELEM_W-1:0] vs1_elem,
    input  logic [`VEX_ELEM_W-1:0] vs2_elem,
    input  logic [`VEX_ELEM_W-1:0] rs1,
    input  logic [4:0]             imm,
    output logic [`VEX_ELEM_W-1:0] lane_res,
    output logic                   cmp_bit
);

    logic [`VEX_ELEM_W-1:0] opa;
    logic [`VEX_ELEM_W-1:0] opb;
    logic [`VEX_ELEM_W-1:0] scalar_ext;
    logic [`VEX_ELEM_W-1:0] imm_ext;
    logic [`VEX_ELEM_W-1:0] alu_res;
    logic                   cmp_res;
    logic                   lt_s;
    logic                   lt_u;
    logic                   eq;

    assign opa = vs2_elem;

    // scalar truncated to sew, then extended
    always_comb begin
        case (vsew)
            vex_pkg::SEW8: begin
                scalar_ext = {{(`VEX_ELEM_W-8){vsignext & rs1[7]}}, rs1[7:0]};
            end
            vex_pkg::SEW16: begin
                scalar_ext = {{(`VEX_ELEM_W-16){vsignext & rs1[15]}}, rs1[15:0]};
            end
            default: begin
                scalar_ext = rs1;
            end
        endcase
    end

    // compares always take a signed immediate
    assign imm_ext = {{(`VEX_ELEM_W-5){(vsignext | vex_pkg::is_cmp(valuop)) & imm[4]}}, imm};

    always_comb begin
        case (opb_sel)
            vex_pkg::OPB_SCALAR: opb = scalar_ext;
            vex_pkg::OPB_IMM:    opb = imm_ext;
            default:             opb = vs1_elem;
        endcase
    end

    assign lt_s = $signed(opa) < $signed(opb);
    assign lt_u = opa < opb;
    assign eq   = opa == opb;

    always_comb begin
        alu_res = '0;
        cmp_res = 1'b0;
        case (valuop)
            vex_pkg::VALU_ADD:  alu_res = opa + opb;
            vex_pkg::VALU_SUB:  alu_res = opa - opb;
            vex_pkg::VALU_AND:  alu_res = opa & opb;
            vex_pkg::VALU_OR:   alu_res = opa | opb;
            vex_pkg::VALU_XOR:  alu_res = opa ^ opb;
            vex_pkg::VALU_MIN:  alu_res = lt_s ? opa : opb;
            vex_pkg::VALU_MAX:  alu_res = lt_s ? opb : opa;
            vex_pkg::VALU_MINU: alu_res = lt_u ? opa : opb;
            vex_pkg::VALU_MAXU: alu_res = lt_u ? opb : opa;
            vex_pkg::VALU_SEQ:  cmp_res = eq;
            vex_pkg::VALU_SNE:  cmp_res = !eq;
            vex_pkg::VALU_SLT:  cmp_res = lt_s;
            vex_pkg::VALU_SLTU: cmp_res = lt_u;
            vex_pkg::VALU_SLE:  cmp_res = lt_s | eq;
            vex_pkg::VALU_SGT:  cmp_res = !(lt_s | eq);
            default: begin
                alu_res = '0;
                cmp_res = 1'b0;
            end
        endcase
    end

    // hold on idle cycles, merger ignores them
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            lane_res <= '0;
            cmp_bit  <= 1'b0;
        end else if (in_valid) begin
            lane_res <= alu_res;
            cmp_bit  <= cmp_res;
        end
    end

    valuop_defined: assert property (@(posedge CLK) disable iff (!arst_n)
        in_valid |-> !$isunknown(valuop) && (valuop <= vex_pkg::VALU_SGT));

endmodule

`default_nettype wire

// ==== design/vex_mask_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vex_params.svh"

module vex_mask_unit (
    input  logic                  CLK,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  logic [`VEX_V0_W-1:0]  v0,
    input  logic                  mask_en,
    input  logic [1:0]            uop_num,
    input  logic [`VEX_VL_W-1:0]  vl,
    output logic [`VEX_LANES-1:0] lane_en
);

    logic [`VEX_LANES-1:0] en_nxt;

    for (genvar i = 0; i < `VEX_LANES; i++) begin : g_lane
        logic [`VEX_VL_W-1:0] elem_idx;

        // element covered by this lane in the current micro-op
        assign elem_idx = `VEX_VL_W'(`VEX_LANES * uop_num + i);

        // tail elements past vl are never written
        assign en_nxt[i] = in_valid && (elem_idx < vl) && (!mask_en || v0[elem_idx]);
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            lane_en <= '0;
        end else begin
            lane_en <= en_nxt;
        end
    end

    // vl counts at most 16 elements
    vl_in_range: assert property (@(posedge CLK) disable iff (!arst_n)
        in_valid |-> (vl <= 16));

endmodule

`default_nettype wire

// ==== design/vex_result_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vex_params.svh"

module vex_result_merge (
    input  logic                                   CLK,
    input  logic                                   arst_n,
    input  logic                                   in_valid,
    input  vex_pkg::valuop_t                       valuop,
    input  logic [1:0]                             uop_num,
    input  logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] vd_dat,
    input  logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] lane_res,
    input  logic [`VEX_LANES-1:0]                  cmp_bit,
    input  logic [`VEX_LANES-1:0]                  lane_en,
    output logic                                   out_valid,
    output logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] out_res,
    output logic [`VEX_LANES-1:0]                  out_lane_mask,
    output logic                                   out_mask_set
);

    logic                                   s1_valid;
    vex_pkg::valuop_t                       s1_op;
    logic [1:0]                             s1_uop;
    logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] s1_vd;
    logic                                   s1_cmp;
    logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] res_nxt;
    logic [`VEX_LANES-1:0]                  lmask_nxt;
    logic                                   mset_nxt;

    // stage 1 lines up with lane ALU and mask unit outputs
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge CLK) begin
        s1_op  <= valuop;
        s1_uop <= uop_num;
        s1_vd  <= vd_dat;
    end

    assign s1_cmp = vex_pkg::is_cmp(s1_op);

    always_comb begin
        res_nxt   = s1_vd;
        lmask_nxt = lane_en;
        mset_nxt  = 1'b0;
        if (s1_cmp) begin
            // mask bits packed into vd word 0
            for (int i = 0; i < `VEX_LANES; i++) begin
                if (lane_en[i]) begin
                    res_nxt[0][`VEX_LANES * s1_uop + i] = cmp_bit[i];
                end
            end
            lmask_nxt = `VEX_LANES'(1);
            mset_nxt  = 1'b1;
        end else begin
            // undisturbed policy on inactive lanes
            for (int i = 0; i < `VEX_LANES; i++) begin
                if (lane_en[i]) begin
                    res_nxt[i] = lane_res[i];
                end
            end
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            out_valid     <= 1'b0;
            out_lane_mask <= '0;
            out_mask_set  <= 1'b0;
        end else begin
            out_valid     <= s1_valid;
            out_lane_mask <= s1_valid ? lmask_nxt : '0;
            out_mask_set  <= s1_valid & mset_nxt;
        end
    end

    always_ff @(posedge CLK) begin
        out_res <= res_nxt;
    end

    // mask unit enables must line up with the stage 1 copy
    lane_en_aligned: assert property (@(posedge CLK) disable iff (!arst_n)
        !s1_valid |-> (lane_en == '0));

endmodule

`default_nettype wire

// ==== design/vex_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vex_params.svh"

module vex_datapath (
    input  logic                                   CLK,
    input  logic                                   arst_n,
    input  logic                                   in_valid,
    input  vex_pkg::valuop_t                       valuop,
    input  vex_pkg::sew_t                          vsew,
    input  logic                                   vsignext,
    input  vex_pkg::opb_sel_t                      opb_sel,
    input  logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] vs1_dat,
    input  logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] vs2_dat,
    input  logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] vd_dat,
    input  logic [`VEX_ELEM_W-1:0]                 rs1,
    input  logic [4:0]                             imm,
    input  logic [`VEX_V0_W-1:0]                   v0,
    input  logic                                   mask_en,
    input  logic [1:0]                             uop_num,
    input  logic [`VEX_VL_W-1:0]                   vl,
    output logic                                   out_valid,
    output logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] out_res,
    output logic [`VEX_LANES-1:0]                  out_lane_mask,
    output logic                                   out_mask_set
);

    logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] lane_res;
    logic [`VEX_LANES-1:0]                  cmp_bit;
    logic [`VEX_LANES-1:0]                  lane_en;

    for (genvar k = 0; k < `VEX_LANES; k++) begin : g_lane
        vex_lane_alu u_lane_alu (
            .CLK      (CLK),
            .arst_n   (arst_n),
            .in_valid (in_valid),
            .valuop   (valuop),
            .vsew     (vsew),
            .vsignext (vsignext),
            .opb_sel  (opb_sel),
            .vs1_elem (vs1_dat[k]),
            .vs2_elem (vs2_dat[k]),
            .rs1      (rs1),
            .imm      (imm),
            .lane_res (lane_res[k]),
            .cmp_bit  (cmp_bit[k])
        );
    end

    vex_mask_unit u_mask_unit (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .v0       (v0),
        .mask_en  (mask_en),
        .uop_num  (uop_num),
        .vl       (vl),
        .lane_en  (lane_en)
    );

    // takes raw controls and vd, delays them itself
    vex_result_merge u_result_merge (
        .CLK           (CLK),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .valuop        (valuop),
        .uop_num       (uop_num),
        .vd_dat        (vd_dat),
        .lane_res      (lane_res),
        .cmp_bit       (cmp_bit),
        .lane_en       (lane_en),
        .out_valid     (out_valid),
        .out_res       (out_res),
        .out_lane_mask (out_lane_mask),
        .out_mask_set  (out_mask_set)
    );

endmodule

`default_nettype wire

// ==== tb/tb_vex_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vex_params.svh"

module tb_vex_datapath;

    logic                                   CLK;
    logic                                   arst_n;
    logic                                   in_valid;
    vex_pkg::valuop_t                       valuop;
    vex_pkg::sew_t                          vsew;
    logic                                   vsignext;
    vex_pkg::opb_sel_t                      opb_sel;
    logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] vs1_dat;
    logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] vs2_dat;
    logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] vd_dat;
    logic [`VEX_ELEM_W-1:0]                 rs1;
    logic [4:0]                             imm;
    logic [`VEX_V0_W-1:0]                   v0;
    logic                                   mask_en;
    logic [1:0]                             uop_num;
    logic [`VEX_VL_W-1:0]                   vl;
    logic                                   out_valid;
    logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] out_res;
    logic [`VEX_LANES-1:0]                  out_lane_mask;
    logic                                   out_mask_set;

    logic [31:0]                            lfsr;
    int                                     cycle_cnt = 0;
    int                                     err_cnt = 0;
    int                                     test_cnt = 0;
    int                                     failed_tests = 0;
    logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] exp_res_q[$];
    logic [`VEX_LANES-1:0]                  exp_lmask_q[$];
    logic                                   exp_mset_q[$];
    int                                     exp_cyc_q[$];

    vex_datapath u_vex_datapath (.*);

    initial CLK = 1'b0;
    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // expected outputs for the inputs currently driven
    function automatic void ref_model(output logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] res,
                                      output logic [`VEX_LANES-1:0] lmask, output logic mset);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic        c;
        logic        cmp_op;
        logic [3:0]  en;
        int          idx;
        cmp_op = valuop >= vex_pkg::VALU_SEQ;
        res = vd_dat;
        for (int i = 0; i < `VEX_LANES; i++) begin
            idx = `VEX_LANES * uop_num + i;
            en[i] = (idx < vl) && (!mask_en || v0[idx]);
            a = vs2_dat[i];
            if (opb_sel == vex_pkg::OPB_SCALAR && vsew == vex_pkg::SEW8) begin
                b = vsignext ? 32'($signed(rs1[7:0])) : 32'(rs1[7:0]);
            end else if (opb_sel == vex_pkg::OPB_SCALAR && vsew == vex_pkg::SEW16) begin
                b = vsignext ? 32'($signed(rs1[15:0])) : 32'(rs1[15:0]);
            end else if (opb_sel == vex_pkg::OPB_SCALAR) begin
                b = rs1;
            end else if (opb_sel == vex_pkg::OPB_IMM) begin
                b = (vsignext || cmp_op) ? 32'($signed(imm)) : 32'(imm);
            end else begin
                b = vs1_dat[i];
            end
            case (valuop)
                vex_pkg::VALU_ADD:  r = a + b;
                vex_pkg::VALU_SUB:  r = a - b;
                vex_pkg::VALU_AND:  r = a & b;
                vex_pkg::VALU_OR:   r = a | b;
                vex_pkg::VALU_XOR:  r = a ^ b;
                vex_pkg::VALU_MIN:  r = ($signed(a) < $signed(b)) ? a : b;
                vex_pkg::VALU_MAX:  r = ($signed(a) > $signed(b)) ? a : b;
                vex_pkg::VALU_MINU: r = (a < b) ? a : b;
                vex_pkg::VALU_MAXU: r = (a > b) ? a : b;
                default:            r = '0;
            endcase
            case (valuop)
                vex_pkg::VALU_SEQ:  c = a == b;
                vex_pkg::VALU_SNE:  c = a != b;
                vex_pkg::VALU_SLT:  c = $signed(a) < $signed(b);
                vex_pkg::VALU_SLTU: c = a < b;
                vex_pkg::VALU_SLE:  c = $signed(a) <= $signed(b);
                default:            c = $signed(a) > $signed(b);
            endcase
            if (cmp_op && en[i]) begin
                res[0][idx] = c;
            end else if (!cmp_op && en[i]) begin
                res[i] = r;
            end
        end
        lmask = cmp_op ? 4'b0001 : en;
        mset = cmp_op;
    endfunction

    function automatic vex_pkg::valuop_t pick_alu_op();
        return vex_pkg::valuop_t'(4'(rand_bits(4) % 9));
    endfunction

    function automatic vex_pkg::valuop_t pick_cmp_op();
        return vex_pkg::valuop_t'(4'(9 + rand_bits(3) % 6));
    endfunction

    task automatic issue_uop(input vex_pkg::valuop_t op, input vex_pkg::opb_sel_t sel,
                             input vex_pkg::sew_t sew, input logic sext, input logic men,
                             input logic [4:0] vlen, input logic [1:0] uop);
        logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] e_res;
        logic [`VEX_LANES-1:0]                  e_lmask;
        logic                                   e_mset;
        @(negedge CLK);
        in_valid = 1'b1;
        valuop = op;
        opb_sel = sel;
        vsew = sew;
        vsignext = sext;
        mask_en = men;
        vl = vlen;
        uop_num = uop;
        for (int k = 0; k < `VEX_LANES; k++) begin
            vs1_dat[k] = rand_bits(32);
            vs2_dat[k] = rand_bits(32);
            vd_dat[k] = rand_bits(32);
            // equal operands now and then for seq/sne/sle
            if (rand_bits(2) == 0) begin
                vs1_dat[k] = vs2_dat[k];
            end
        end
        rs1 = rand_bits(32);
        imm = 5'(rand_bits(5));
        v0 = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
        ref_model(e_res, e_lmask, e_mset);
        exp_res_q.push_back(e_res);
        exp_lmask_q.push_back(e_lmask);
        exp_mset_q.push_back(e_mset);
        exp_cyc_q.push_back(cycle_cnt);
    endtask

    task automatic go_idle(input int n);
        repeat (n) begin
            @(negedge CLK);
            in_valid = 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        int t;
        go_idle(2);
        for (t = 0; t < 10 && exp_res_q.size() != 0; t++) begin
            @(posedge CLK);
        end
        if (exp_res_q.size() != 0) begin
            $display("timeout in %s: %0d micro-ops never came out", name, exp_res_q.size());
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            test_cnt++;
            if (err_cnt != err_before) begin
                failed_tests++;
            end
            $display("test %0d %s: %s", test_cnt, name, (err_cnt == err_before) ? "ok" : "failed");
        end
    endtask

    always @(negedge CLK) begin : compare_outputs
        logic [`VEX_LANES-1:0][`VEX_ELEM_W-1:0] e_res;
        logic [`VEX_LANES-1:0]                  e_lmask;
        logic                                   e_mset;
        int                                     e_cyc;
        if (arst_n && out_valid && exp_res_q.size() == 0) begin
            $display("at %0t ns out_valid is high with no micro-op outstanding", $time);
            err_cnt++;
        end else if (arst_n && out_valid) begin
            e_res = exp_res_q.pop_front();
            e_lmask = exp_lmask_q.pop_front();
            e_mset = exp_mset_q.pop_front();
            e_cyc = exp_cyc_q.pop_front();
            if (cycle_cnt - e_cyc != 2) begin
                $display("at %0t ns out_valid came %0d cycles after in_valid, not 2",
                         $time, cycle_cnt - e_cyc);
                err_cnt++;
            end
            for (int k = 0; k < `VEX_LANES; k++) begin
                if (out_res[k] !== e_res[k]) begin
                    $display("ERROR %0t ns out_res[%0d] expected %08h actual %08h",
                             $time, k, e_res[k], out_res[k]);
                    err_cnt++;
                end
            end
            if (out_lane_mask !== e_lmask) begin
                $display("ERROR %0t ns out_lane_mask expected %b actual %b",
                         $time, e_lmask, out_lane_mask);
                err_cnt++;
            end
            if (out_mask_set !== e_mset) begin
                $display("ERROR %0t ns out_mask_set expected %b actual %b",
                         $time, e_mset, out_mask_set);
                err_cnt++;
            end
        end else if (arst_n) begin
            if (out_lane_mask !== '0 || out_mask_set !== 1'b0) begin
                $display("ERROR %0t ns out_lane_mask/out_mask_set expected 0000/0 actual %b/%b",
                         $time, out_lane_mask, out_mask_set);
                err_cnt++;
            end
            if (exp_cyc_q.size() != 0 && cycle_cnt - exp_cyc_q[0] >= 2) begin
                $display("at %0t ns out_valid did not come 2 cycles after in_valid", $time);
                err_cnt++;
                e_res = exp_res_q.pop_front();
                e_lmask = exp_lmask_q.pop_front();
                e_mset = exp_mset_q.pop_front();
                e_cyc = exp_cyc_q.pop_front();
            end
        end
    end

    initial begin
        int err_before;
        lfsr = 32'h107aa0c6;
        arst_n = 1'b0;
        in_valid = 1'b0;
        valuop = vex_pkg::VALU_ADD;
        vsew = vex_pkg::SEW32;
        vsignext = 1'b0;
        opb_sel = vex_pkg::OPB_VEC;
        vs1_dat = '0;
        vs2_dat = '0;
        vd_dat = '0;
        rs1 = '0;
        imm = '0;
        v0 = '0;
        mask_en = 1'b0;
        uop_num = '0;
        vl = '0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;

        err_before = err_cnt;
        go_idle(10);
        finish_test("idle after reset", err_before);

        // back to back, every lane active
        err_before = err_cnt;
        repeat (40) begin
            issue_uop(pick_alu_op(), vex_pkg::OPB_VEC, vex_pkg::SEW32, 1'b0, 1'b0, 5'd16,
                      2'(rand_bits(2)));
        end
        finish_test("vector-vector ops", err_before);

        err_before = err_cnt;
        for (int s = 0; s < 3; s++) begin
            for (int x = 0; x < 2; x++) begin
                repeat (4) begin
                    issue_uop(pick_alu_op(), vex_pkg::OPB_SCALAR, vex_pkg::sew_t'(2'(s)), x[0],
                              1'b0, 5'd16, 2'(rand_bits(2)));
                end
            end
        end
        for (int x = 0; x < 2; x++) begin
            repeat (6) begin
                issue_uop(pick_alu_op(), vex_pkg::OPB_IMM, vex_pkg::SEW32, x[0], 1'b0, 5'd16,
                          2'(rand_bits(2)));
            end
        end
        finish_test("scalar and immediate broadcast", err_before);

        err_before = err_cnt;
        for (int u = 0; u < 4; u++) begin
            repeat (12) begin
                issue_uop(pick_alu_op(), vex_pkg::opb_sel_t'(2'(rand_bits(2) % 3)),
                          vex_pkg::sew_t'(2'(rand_bits(2) % 3)), 1'(rand_bits(1)), 1'b1,
                          5'(rand_bits(4)), 2'(u));
            end
        end
        finish_test("masked ops below vl", err_before);

        err_before = err_cnt;
        repeat (48) begin
            issue_uop(pick_cmp_op(), vex_pkg::opb_sel_t'(2'(rand_bits(2) % 3)),
                      vex_pkg::sew_t'(2'(rand_bits(2) % 3)), 1'(rand_bits(1)),
                      1'(rand_bits(1)), 5'(rand_bits(5) % 17), 2'(rand_bits(2)));
        end
        finish_test("compare mask bits", err_before);

        $display("tests %0d, failed %0d, errors %0d", test_cnt, failed_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
design/vex_pkg.sv
design/vex_lane_alu.sv
design/vex_mask_unit.sv
design/vex_result_merge.sv
design/vex_datapath.sv
tb/tb_vex_datapath.sv

// ==== Makefile ====
TOP := tb_vex_datapath

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
